//--- src/battleTypesPkg.sv
package battleTypesPkg;

    // health of either fighter, 0 to 127
    typedef logic [6:0] healthT;

    // player moves, one per known key
    typedef enum logic [2:0]
    {
        PUNCH,
        HEAVY,
        JAB,
        FLURRY,
        PASS
    } attackOpT;

    // turn sequencing
    typedef enum logic [2:0]
    {
        IDLE,
        PLAYER_WAIT,
        PLAYER_HIT,
        ENEMY_HIT,
        OVER
    } turnStateT;

    // battle result
    typedef enum logic [1:0]
    {
        NONE,
        PLAYER_WON,
        ENEMY_WON
    } outcomeT;

    // keyboard scan codes of the five moves
    localparam logic [7:0] KEY_P = 8'h19;
    localparam logic [7:0] KEY_H = 8'h0B;
    localparam logic [7:0] KEY_J = 8'h0D;
    localparam logic [7:0] KEY_F = 8'h0F;
    localparam logic [7:0] KEY_N = 8'h11;

    // damage dealt to the enemy by each move
    function automatic healthT attackDamage(attackOpT op);
        healthT dmg;
        case (op)
            PUNCH:   dmg = 7'd20;
            HEAVY:   dmg = 7'd25;
            JAB:     dmg = 7'd8;
            FLURRY:  dmg = 7'd12;
            default: dmg = 7'd0;
        endcase
        return dmg;
    endfunction

endpackage

//--- src/screenPkg.sv
package screenPkg;

    // signed so off-screen positions still compare sensibly
    typedef logic signed [10:0] coordT;

    // 4 bits per channel, red in the top nibble
    typedef struct packed
    {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } colourT;

    // enemy bar, upper left of the screen
    localparam coordT ENEMY_BAR_X = 11'sd105;
    localparam coordT ENEMY_BAR_Y0 = 11'sd67;
    localparam coordT ENEMY_BAR_Y1 = 11'sd71;

    // player bar, lower right
    localparam coordT PLAYER_BAR_X = 11'sd349;
    localparam coordT PLAYER_BAR_Y0 = 11'sd181;
    localparam coordT PLAYER_BAR_Y1 = 11'sd184;

    // orange bars on a black backdrop
    localparam colourT BAR_COLOUR = 12'hF64;
    localparam colourT BACKDROP_COLOUR = 12'h000;

endpackage

//--- src/keyDecoder.sv
`timescale 1ns/1ps

module keyDecoder (
    input  logic                     frame_clk,
    input  logic                     debug,
    input  logic [7:0]               keycode,
    input  logic                     keyValid,
    output logic                     keyReady,
    output battleTypesPkg::attackOpT moveOp,
    output logic                     moveValid,
    input  logic                     moveReady
);
    import battleTypesPkg::*;

    attackOpT decodedOp;
    logic     keyKnown;
    logic     keyTaken;
    attackOpT bufOp;
    logic     bufFull;

    // scan code to move lookup
    always_comb
    begin
        keyKnown = 1'b1;
        decodedOp = PASS;
        case (keycode)
            KEY_P:   decodedOp = PUNCH;
            KEY_H:   decodedOp = HEAVY;
            KEY_J:   decodedOp = JAB;
            KEY_F:   decodedOp = FLURRY;
            KEY_N:   decodedOp = PASS;
            // anything else is swallowed
            default: keyKnown = 1'b0;
        endcase
    end

    // open when empty or draining this cycle
    assign keyReady = !bufFull || moveReady;
    assign keyTaken = keyValid && keyReady;

    // occupancy of the single slot
    always_ff @(posedge frame_clk or posedge debug)
    begin
        if (debug)
            bufFull <= 1'b0;
        else if (keyTaken && keyKnown)
            // refill, possibly while the old move leaves
            bufFull <= 1'b1;
        else if (moveReady)
            bufFull <= 1'b0;
    end

    // slot contents
    always_ff @(posedge frame_clk)
    begin
        if (keyTaken && keyKnown)
            bufOp <= decodedOp;
    end

    assign moveOp = bufOp;
    assign moveValid = bufFull;

    // a stalled move must stay put until the engine takes it
    assert property (@(posedge frame_clk) disable iff (debug)
        moveValid && !moveReady |=> moveValid && $stable(moveOp));

endmodule

//--- src/turnEngine.sv
`timescale 1ns/1ps

module turnEngine #(
    parameter int unsigned MaxHealth = 94,
    parameter int unsigned EnemyDamage = 8
) (
    input  logic                     frame_clk,
    input  logic                     debug,
    input  logic                     battleStart,
    input  battleTypesPkg::attackOpT moveOp,
    input  logic                     moveValid,
    output logic                     moveReady,
    output battleTypesPkg::healthT   playerHealth,
    output battleTypesPkg::healthT   enemyHealth,
    output battleTypesPkg::outcomeT  outcome
);
    import battleTypesPkg::*;

    // parameters folded into health width
    localparam healthT FullHealth = healthT'(MaxHealth);
    localparam healthT EnemyHit = healthT'(EnemyDamage);

    turnStateT state;
    attackOpT  heldMove;
    healthT    enemyNext;
    healthT    playerNext;

    // subtraction that stops at zero
    function automatic healthT subSat(healthT h, healthT dmg);
        healthT result;
        if (dmg >= h)
            result = '0;
        else
            result = h - dmg;
        return result;
    endfunction

    // only the waiting state takes a move
    assign moveReady = (state == PLAYER_WAIT);

    // health after the pending hit of each side
    assign enemyNext = subSat(enemyHealth, attackDamage(heldMove));
    assign playerNext = subSat(playerHealth, EnemyHit);

    // turn sequencing, health and result
    always_ff @(posedge frame_clk or posedge debug)
    begin
        if (debug)
        begin
            state <= IDLE;
            playerHealth <= FullHealth;
            enemyHealth <= FullHealth;
            outcome <= NONE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (battleStart)
                        state <= PLAYER_WAIT;
                PLAYER_WAIT:
                    // handshake completes here since moveReady is high
                    if (moveValid)
                        state <= PLAYER_HIT;
                PLAYER_HIT:
                begin
                    // player strikes first
                    enemyHealth <= enemyNext;
                    if (enemyNext == '0)
                    begin
                        state <= OVER;
                        outcome <= PLAYER_WON;
                    end
                    else
                        state <= ENEMY_HIT;
                end
                ENEMY_HIT:
                begin
                    // fixed counter-attack
                    playerHealth <= playerNext;
                    if (playerNext == '0)
                    begin
                        state <= OVER;
                        outcome <= ENEMY_WON;
                    end
                    else
                        state <= PLAYER_WAIT;
                end
                // battle done, only reset leaves
                OVER:
                    state <= OVER;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // move captured with the handshake
    always_ff @(posedge frame_clk)
    begin
        if (moveValid && moveReady)
            heldMove <= moveOp;
    end

    // damage only ever takes health away
    assert property (@(posedge frame_clk) disable iff (debug)
        $past(!debug) |-> (playerHealth <= $past(playerHealth))
                          && (enemyHealth <= $past(enemyHealth)));

    // no move accepted mid-turn or after the end
    assert property (@(posedge frame_clk) disable iff (debug)
        moveReady |-> (outcome == NONE) && !$past(moveValid && moveReady));

endmodule

//--- src/healthBarRenderer.sv
`timescale 1ns/1ps

module healthBarRenderer #(
    parameter int unsigned MaxHealth = 94
) (
    input  logic                   frame_clk,
    input  logic                   debug,
    input  screenPkg::coordT       pixelX,
    input  screenPkg::coordT       pixelY,
    input  logic                   pixelValid,
    output logic                   pixelReady,
    input  battleTypesPkg::healthT playerHealth,
    input  battleTypesPkg::healthT enemyHealth,
    output screenPkg::colourT      colour,
    output logic                   colourValid,
    input  logic                   colourReady
);
    import screenPkg::*;

    coordT  enemyBarEnd;
    coordT  playerBarEnd;
    logic   enemyBarHit;
    logic   playerBarHit;
    logic   pipeOpen;
    logic   pixelTaken;
    logic   s1Valid;
    logic   s1Ready;
    logic   s1EnemyHit;
    logic   s1PlayerHit;
    logic   s2Valid;
    logic   s2Ready;
    colourT s2Colour;

    // last lit column of each bar, health wide past the start
    assign enemyBarEnd = ENEMY_BAR_X + coordT'({4'b0000, enemyHealth});
    assign playerBarEnd = PLAYER_BAR_X + coordT'({4'b0000, playerHealth});

    // inclusive rectangle tests on the incoming pixel
    assign enemyBarHit = (pixelX >= ENEMY_BAR_X) && (pixelX <= enemyBarEnd)
                         && (pixelY >= ENEMY_BAR_Y0) && (pixelY <= ENEMY_BAR_Y1);
    assign playerBarHit = (pixelX >= PLAYER_BAR_X) && (pixelX <= playerBarEnd)
                          && (pixelY >= PLAYER_BAR_Y0) && (pixelY <= PLAYER_BAR_Y1);

    // stage 2 frees up when empty or its colour is taken
    assign s2Ready = !s2Valid || colourReady;
    // stage 1 frees up when empty or moving into stage 2
    assign s1Ready = !s1Valid || s2Ready;

    // requests held off for the first cycle out of reset
    assign pixelReady = pipeOpen && s1Ready;
    assign pixelTaken = pixelValid && pixelReady;

    // pipeline occupancy
    always_ff @(posedge frame_clk or posedge debug)
    begin
        if (debug)
        begin
            pipeOpen <= 1'b0;
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end
        else
        begin
            pipeOpen <= 1'b1;
            if (s1Ready)
                s1Valid <= pixelTaken;
            if (s2Ready)
                s2Valid <= s1Valid;
        end
    end

    // stage 1 keeps the hit flags, health as of acceptance
    always_ff @(posedge frame_clk)
    begin
        if (pixelTaken)
        begin
            s1EnemyHit <= enemyBarHit;
            s1PlayerHit <= playerBarHit;
        end
    end

    // stage 2 picks the colour
    always_ff @(posedge frame_clk)
    begin
        if (s1Valid && s2Ready)
            s2Colour <= (s1EnemyHit || s1PlayerHit) ? BAR_COLOUR : BACKDROP_COLOUR;
    end

    assign colour = s2Colour;
    assign colourValid = s2Valid;

    // engine healths must fit the drawn bar width
    assert property (@(posedge frame_clk) disable iff (debug)
        (playerHealth <= MaxHealth) && (enemyHealth <= MaxHealth));

endmodule

//--- src/battleScreen.sv
`timescale 1ns/1ps

module battleScreen #(
    parameter int unsigned MaxHealth = 94,
    parameter int unsigned EnemyDamage = 8
) (
    input  logic                    frame_clk,
    input  logic                    debug,
    input  logic [7:0]              keycode,
    input  logic                    keyValid,
    output logic                    keyReady,
    input  logic                    battleStart,
    input  screenPkg::coordT        pixelX,
    input  screenPkg::coordT        pixelY,
    input  logic                    pixelValid,
    output logic                    pixelReady,
    output screenPkg::colourT       colour,
    output logic                    colourValid,
    input  logic                    colourReady,
    output battleTypesPkg::healthT  playerHealth,
    output battleTypesPkg::healthT  enemyHealth,
    output battleTypesPkg::outcomeT outcome
);
    import battleTypesPkg::*;

    // move stream between decoder and engine
    attackOpT moveOp;
    logic     moveValid;
    logic     moveReady;

    // keycodes in, moves out
    keyDecoder keyDec (
        .frame_clk (frame_clk),
        .debug     (debug),
        .keycode   (keycode),
        .keyValid  (keyValid),
        .keyReady  (keyReady),
        .moveOp    (moveOp),
        .moveValid (moveValid),
        .moveReady (moveReady)
    );

    // battle rules
    turnEngine #(
        .MaxHealth   (MaxHealth),
        .EnemyDamage (EnemyDamage)
    ) engine (
        .frame_clk    (frame_clk),
        .debug        (debug),
        .battleStart  (battleStart),
        .moveOp       (moveOp),
        .moveValid    (moveValid),
        .moveReady    (moveReady),
        .playerHealth (playerHealth),
        .enemyHealth  (enemyHealth),
        .outcome      (outcome)
    );

    // health bars drawn from the live healths
    healthBarRenderer #(
        .MaxHealth (MaxHealth)
    ) renderer (
        .frame_clk    (frame_clk),
        .debug        (debug),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .pixelValid   (pixelValid),
        .pixelReady   (pixelReady),
        .playerHealth (playerHealth),
        .enemyHealth  (enemyHealth),
        .colour       (colour),
        .colourValid  (colourValid),
        .colourReady  (colourReady)
    );

endmodule

//--- tests/battleScreenTb.sv
`timescale 1ns/1ps

module battleScreenTb;
    import battleTypesPkg::*;
    import screenPkg::*;

    localparam int MaxHealth = 94;
    localparam int EnemyDamage = 8;
    localparam time ClkPeriod = 100ns;
    localparam time DriveDelay = 10ns;
    localparam string StimFile = "tests/battleStimulus.txt";

    logic       frame_clk;
    logic       debug;
    logic [7:0] keycode;
    logic       keyValid;
    logic       keyReady;
    logic       battleStart;
    coordT      pixelX;
    coordT      pixelY;
    logic       pixelValid;
    logic       pixelReady;
    colourT     colour;
    logic       colourValid;
    logic       colourReady;
    healthT     playerHealth;
    healthT     enemyHealth;
    outcomeT    outcome;

    int          passCount = 0;
    int          errorCount = 0;
    int          lineTotal = 0;
    // colours still owed by the renderer, oldest first
    logic [11:0] expColours[$];
    int          probeLines[$];

    battleScreen #(
        .MaxHealth   (MaxHealth),
        .EnemyDamage (EnemyDamage)
    ) i_dut (
        .frame_clk    (frame_clk),
        .debug        (debug),
        .keycode      (keycode),
        .keyValid     (keyValid),
        .keyReady     (keyReady),
        .battleStart  (battleStart),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .pixelValid   (pixelValid),
        .pixelReady   (pixelReady),
        .colour       (colour),
        .colourValid  (colourValid),
        .colourReady  (colourReady),
        .playerHealth (playerHealth),
        .enemyHealth  (enemyHealth),
        .outcome      (outcome)
    );

    initial
    begin
        frame_clk = 1'b0;
        forever
            #(ClkPeriod / 2) frame_clk = ~frame_clk;
    end

    // drive point, shortly after the rising edge
    task automatic nextDrive();
        @(posedge frame_clk);
        #(DriveDelay);
    endtask

    // every block idle straight out of reset
    task automatic applyReset();
        debug = 1'b1;
        repeat (3)
            nextDrive();
        debug = 1'b0;
        if (keyReady !== 1'b1 || pixelReady !== 1'b0 || colourValid !== 1'b0
            || int'(playerHealth) != MaxHealth || int'(enemyHealth) != MaxHealth
            || outcome !== NONE)
        begin
            errorCount++;
            $display("[ERROR] %0t reset: ready %b %b colourValid %b health %0d %0d outcome %0d",
                     $time, keyReady, pixelReady, colourValid, enemyHealth, playerHealth,
                     outcome);
        end
        else
        begin
            passCount++;
            $display("reset ok: enemy %0d player %0d", enemyHealth, playerHealth);
        end
    endtask

    // leave IDLE, done once the engine takes moves
    task automatic startBattle();
        battleStart = 1'b1;
        @(negedge frame_clk);
        while (!i_dut.moveReady)
            @(negedge frame_clk);
        nextDrive();
        battleStart = 1'b0;
    endtask

    // hold the key until the decoder takes it
    task automatic sendKey(input logic [7:0] code);
        keycode = code;
        keyValid = 1'b1;
        @(negedge frame_clk);
        while (!keyReady)
            @(negedge frame_clk);
        nextDrive();
        keyValid = 1'b0;
    endtask

    // turn done when engine waits with nothing buffered, or battle over
    task automatic waitTurn();
        @(negedge frame_clk);
        while (!(i_dut.moveReady && !i_dut.moveValid) && outcome == NONE)
            @(negedge frame_clk);
        nextDrive();
    endtask

    task automatic sendPixel(input int x, input int y, input logic [11:0] expColour,
                             input int lineNo);
        expColours.push_back(expColour);
        probeLines.push_back(lineNo);
        pixelX = coordT'(x);
        pixelY = coordT'(y);
        pixelValid = 1'b1;
        @(negedge frame_clk);
        while (!pixelReady)
            @(negedge frame_clk);
        nextDrive();
        pixelValid = 1'b0;
    endtask

    // all owed colours back, pipeline then empty
    task automatic drainColours();
        while (expColours.size() != 0)
            @(negedge frame_clk);
        nextDrive();
        if (colourValid)
        begin
            errorCount++;
            $display("a colour came back with no pixel request outstanding");
        end
    endtask

    task automatic checkBattle(input string what, input int expEnemy, input int expPlayer,
                               input int expOutcome);
        if (int'(enemyHealth) != expEnemy || int'(playerHealth) != expPlayer
            || int'(outcome) != expOutcome)
        begin
            errorCount++;
            $display("[ERROR] %0t %s: enemy %0d player %0d outcome %0d, expected %0d %0d %0d",
                     $time, what, enemyHealth, playerHealth, outcome,
                     expEnemy, expPlayer, expOutcome);
        end
        else
        begin
            passCount++;
            $display("%s ok: enemy %0d player %0d outcome %0d", what, enemyHealth,
                     playerHealth, outcome);
        end
    endtask

    task automatic badLine(input int lineNo);
        errorCount++;
        $display("stimulus line %0d could not be read", lineNo);
    endtask

    // blank lines and # comments carry no command
    function automatic bit isCommand(input string line);
        return line.len() > 0 && line[0] != "#" && line[0] != "\n" && line[0] != "\r";
    endfunction

    // colour sink with random back-pressure, checks request order
    initial
    begin
        logic [11:0] expColour;
        int          probeLine;
        // seeded first draw also sets the starting level
        colourReady = ($urandom(32'hd0e9_9980) % 4) != 0;
        forever
        begin
            nextDrive();
            colourReady = ($urandom % 4) != 0;
            // a transfer seen here lands on the coming edge
            @(negedge frame_clk);
            if (colourValid && colourReady)
            begin
                if (expColours.size() == 0)
                begin
                    errorCount++;
                    $display("a colour came back with no pixel request outstanding");
                end
                else
                begin
                    expColour = expColours.pop_front();
                    probeLine = probeLines.pop_front();
                    if (colour !== expColour)
                    begin
                        errorCount++;
                        $display("[ERROR] %0t probe line %0d: colour %h, expected %h",
                                 $time, probeLine, colour, expColour);
                    end
                    else
                    begin
                        passCount++;
                        $display("probe line %0d ok: colour %h", probeLine, colour);
                    end
                end
            end
        end
    end

    // run limit scales with the stimulus length
    initial
    begin
        wait (lineTotal > 0);
        #(lineTotal * 200 * ClkPeriod);
        $display("timeout: stimulus not finished within %0d cycles", lineTotal * 200);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int         fd;
        int         lineNo;
        int         fields;
        int         a;
        int         b;
        int         c;
        int         d;
        int         e;
        int         f;
        logic [7:0] cmd;
        string      line;
        debug = 1'b1;
        keycode = 8'h00;
        keyValid = 1'b0;
        battleStart = 1'b0;
        pixelX = '0;
        pixelY = '0;
        pixelValid = 1'b0;
        lineNo = 0;
        fd = $fopen(StimFile, "r");
        if (fd == 0)
        begin
            $display("stimulus file %s could not be opened", StimFile);
            $display("test failed");
        end
        else
        begin
            // first pass only sizes the watchdog
            while ($fgets(line, fd) != 0)
                if (isCommand(line))
                    lineTotal++;
            $fclose(fd);
            fd = $fopen(StimFile, "r");
            applyReset();
            while ($fgets(line, fd) != 0)
            begin
                lineNo++;
                if (!isCommand(line))
                    continue;
                cmd = line[0];
                case (cmd)
                    "R":
                    begin
                        drainColours();
                        applyReset();
                    end
                    "S":
                    begin
                        fields = $sscanf(line, "%c %d %d %d", cmd, a, b, c);
                        if (fields != 4)
                            badLine(lineNo);
                        else
                        begin
                            startBattle();
                            checkBattle("battle start", a, b, c);
                        end
                    end
                    "K":
                    begin
                        fields = $sscanf(line, "%c %h %d %d %d", cmd, a, b, c, d);
                        if (fields != 5)
                            badLine(lineNo);
                        else
                        begin
                            sendKey(8'(a));
                            waitTurn();
                            checkBattle($sformatf("key %h", a[7:0]), b, c, d);
                        end
                    end
                    "B":
                    begin
                        fields = $sscanf(line, "%c %h %h %h %d %d %d", cmd, a, b, c, d, e, f);
                        if (fields != 7)
                            badLine(lineNo);
                        else
                        begin
                            // later keys wait behind the turn in progress
                            sendKey(8'(a));
                            sendKey(8'(b));
                            sendKey(8'(c));
                            waitTurn();
                            checkBattle($sformatf("burst line %0d", lineNo), d, e, f);
                        end
                    end
                    "P":
                    begin
                        fields = $sscanf(line, "%c %d %d %h", cmd, a, b, c);
                        if (fields != 4)
                            badLine(lineNo);
                        else
                            sendPixel(a, b, c[11:0], lineNo);
                    end
                    "D":
                        drainColours();
                    default:
                        badLine(lineNo);
                endcase
            end
            $fclose(fd);
            drainColours();
            $display("%0d checks passed, %0d failed", passCount, errorCount);
            if (errorCount == 0)
                $display("test passed");
            else
                $display("test failed");
        end
        $finish;
    end

endmodule

//--- tests/battleStimulus.txt
# R reset | S enemy player outcome | K key(hex) enemy player outcome | D drain colours
# B key key key enemy player outcome | P x y colour(hex); outcome 0 none 1 player 2 enemy
S 94 94 0
K 19 74 86 0
K 0B 49 78 0
K 0D 41 70 0
K 0F 29 62 0
K 11 29 54 0
K 2A 29 54 0
P 105 67 F64
P 134 71 F64
P 135 69 000
P 104 69 000
P 120 66 000
P 120 72 000
P 349 181 F64
P 403 184 F64
P 404 182 000
P 380 180 000
P 380 185 000
D
B 0D 0D 11 13 30 0
P 118 68 F64
P 119 68 000
P 379 183 F64
P 380 183 000
D
K 19 0 30 1
K 0B 0 30 1
P 105 69 F64
P 106 69 000
D
R
S 94 94 0
K 11 94 86 0
K 11 94 78 0
K 11 94 70 0
K 11 94 62 0
K 11 94 54 0
K 11 94 46 0
K 11 94 38 0
K 11 94 30 0
K 11 94 22 0
K 11 94 14 0
K 11 94 6 0
K 11 94 0 2
K 19 94 0 2
P 349 182 F64
P 350 182 000
P 199 70 F64
P 200 70 000
D

//--- battleScreen.f
src/battleTypesPkg.sv
src/screenPkg.sv
src/keyDecoder.sv
src/turnEngine.sv
src/healthBarRenderer.sv
src/battleScreen.sv
tests/battleScreenTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# build the battle screen testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module battleScreenTb \
    -f battleScreen.f -o battleSim || { echo "build failed"; exit 1; }
simOut="$(./obj_dir/battleSim)"
echo "$simOut"
# pass only if the pass line was printed
echo "$simOut" | grep -qx "test passed" && exit 0 || exit 1
